//--- design/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ==========================================================
// Register file sizes
// ==========================================================

// Architectural registers x0 to x31
`define RN_ARCH_REGS 32
// Physical registers shared by committed and in-flight values
`define RN_PHYS_REGS 64

// Tag widths for the two register spaces
`define RN_ARCH_W 5
`define RN_PHYS_W 6

// ==========================================================
// Rename group and free list
// ==========================================================

// Instructions renamed per cycle
`define RN_WIDTH 3
// Free list capacity, physical count minus architectural count
`define RN_FREE_DEPTH 32
// Free count width, holds 0 up to RN_FREE_DEPTH inclusive
`define RN_CNT_W 6

`endif

//--- design/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

    // ==========================================================
    // Register tags
    // ==========================================================

    // Architectural register number as seen by decode
    typedef logic [`RN_ARCH_W-1:0] arch_tag_t;

    // Physical register number in the unified register file
    typedef logic [`RN_PHYS_W-1:0] phys_tag_t;

    // ==========================================================
    // Decode to rename
    // ==========================================================

    // One decoded instruction slot
    typedef struct packed {
        logic      valid;
        arch_tag_t rs1;
        arch_tag_t rs2;
        arch_tag_t rd;
        // Instruction writes rd
        logic      rd_we;
    } rename_req_t;

    // ==========================================================
    // Rename to dispatch
    // ==========================================================

    // One renamed instruction slot
    typedef struct packed {
        logic      valid;
        phys_tag_t rs1_phys;
        phys_tag_t rs2_phys;
        // Newly allocated destination, 0 when nothing was allocated
        phys_tag_t rd_phys;
        // Mapping being replaced, the ROB frees it at commit
        phys_tag_t old_rd_phys;
    } rename_rsp_t;

    // One retired instruction returning its old physical register
    typedef struct packed {
        logic      valid;
        phys_tag_t free_phys;
    } commit_t;

endpackage

//--- design/phys_reg_free_list.sv
`include "rename_defines.svh"

module phys_reg_free_list (
    input  logic                                  clk,
    input  logic                                  reset,
    // Grant mask from the alias table
    // Slots without a destination leave holes, so grants need not be contiguous
    input  logic [`RN_WIDTH-1:0]                  pop,
    // Oldest free tags with entry 0 at the head
    output rename_pkg::phys_tag_t [`RN_WIDTH-1:0] head_tags,
    output logic [`RN_CNT_W-1:0]                  count,
    // Tags released by the ROB at commit
    input  rename_pkg::commit_t [`RN_WIDTH-1:0]   push
);

    // Depth is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(`RN_FREE_DEPTH);

    // ==========================================================
    // Storage and pointers
    // ==========================================================

    // Ring of free physical tags
    rename_pkg::phys_tag_t slots [`RN_FREE_DEPTH];

    // Head points at the oldest free tag
    logic [PTR_W-1:0] head_q;
    // Tail points at the next empty slot
    logic [PTR_W-1:0] tail_q;
    // Number of tags held
    logic [`RN_CNT_W-1:0] count_q;

    // Per-cycle pop and push totals
    logic [`RN_CNT_W-1:0] n_pop;
    logic [`RN_CNT_W-1:0] n_push;

    // Offset from tail for each push slot after compaction
    logic [PTR_W-1:0] push_ofs [`RN_WIDTH];

    // ==========================================================
    // Read side
    // ==========================================================

    // Expose the three oldest entries
    // Entries past count are stale and never granted
    always_comb begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            head_tags[k] = slots[head_q + PTR_W'(k)];
        end
    end

    assign count = count_q;

    // ==========================================================
    // Pop and push accounting
    // ==========================================================

    always_comb begin
        n_pop  = '0;
        n_push = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            // Valid pushes before slot k decide where slot k lands
            push_ofs[k] = n_push[PTR_W-1:0];
            if (pop[k]) begin
                n_pop = n_pop + 1'b1;
            end
            if (push[k].valid) begin
                n_push = n_push + 1'b1;
            end
        end
    end

    // ==========================================================
    // State update
    // ==========================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Full ring holding the tags above the architectural range
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= `RN_CNT_W'(`RN_FREE_DEPTH);
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                slots[i] <= rename_pkg::phys_tag_t'(`RN_ARCH_REGS + i);
            end
        end else begin
            // Consume granted tags from the head
            head_q  <= head_q + n_pop[PTR_W-1:0];
            // Append released tags with the gaps between valid pushes squeezed out
            tail_q  <= tail_q + n_push[PTR_W-1:0];
            count_q <= count_q - n_pop + n_push;
            for (int k = 0; k < `RN_WIDTH; k++) begin
                if (push[k].valid) begin
                    slots[tail_q + push_ofs[k]] <= push[k].free_phys;
                end
            end
        end
    end

    // ==========================================================
    // Checks
    // ==========================================================

    // The alias table grants only what the count allows
    a_pop_within_count : assert property (
        @(posedge clk) disable iff (!reset)
        n_pop <= count_q
    ) else $error("free list popped %0d with count %0d", n_pop, count_q);

    // The ROB never returns more tags than were handed out
    a_count_bounded : assert property (
        @(posedge clk) disable iff (!reset)
        count_q <= `RN_FREE_DEPTH
    ) else $error("free list count %0d above depth", count_q);

endmodule

//--- design/register_alias_table.sv
`include "rename_defines.svh"

module register_alias_table (
    input  logic                                    clk,
    input  logic                                    reset,
    // Decoded group, slot 0 is oldest
    input  rename_pkg::rename_req_t [`RN_WIDTH-1:0] req,
    // Oldest free tags from the free list
    input  rename_pkg::phys_tag_t [`RN_WIDTH-1:0]   head_tags,
    input  logic [`RN_CNT_W-1:0]                    free_count,
    output rename_pkg::rename_rsp_t [`RN_WIDTH-1:0] rsp,
    // Level per slot, high when that many tags are free
    output logic [`RN_WIDTH-1:0]                    ready,
    // Grants, also the pop mask for the free list
    output logic [`RN_WIDTH-1:0]                    pop
);

    // ==========================================================
    // Mapping table
    // ==========================================================

    // Current physical register of each architectural register
    rename_pkg::phys_tag_t map_q [`RN_ARCH_REGS];

    // Slot writes x0
    logic [`RN_WIDTH-1:0] rd_zero;
    // Slot wants a new destination register
    logic [`RN_WIDTH-1:0] need;
    // Tag handed to each granted slot, 0 otherwise
    rename_pkg::phys_tag_t new_tag [`RN_WIDTH];

    // ==========================================================
    // Allocation
    // ==========================================================

    always_comb begin
        // Needing slots seen so far in this group
        logic [`RN_CNT_W-1:0] n_need;

        n_need = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            rd_zero[k] = (req[k].rd == '0);
            need[k]    = req[k].valid && req[k].rd_we && !rd_zero[k];

            // Ready depends on the count alone, not on this group
            ready[k] = (free_count > k);

            pop[k]     = 1'b0;
            new_tag[k] = '0;
            if (need[k]) begin
                // n-th needing slot takes the n-th tag if one is there
                if (free_count > n_need) begin
                    pop[k]     = 1'b1;
                    new_tag[k] = head_tags[n_need];
                end
                n_need = n_need + 1'b1;
            end
        end
    end

    // ==========================================================
    // Lookup and intra-group bypass
    // ==========================================================

    always_comb begin
        // Previous mapping of rd as seen by the current slot
        rename_pkg::phys_tag_t old_tag;

        for (int k = 0; k < `RN_WIDTH; k++) begin
            // Start from the table, x0 reads entry 0 which holds 0
            rsp[k].rs1_phys = map_q[req[k].rs1];
            rsp[k].rs2_phys = map_q[req[k].rs2];
            old_tag         = map_q[req[k].rd];

            // Older granted slots override in order, so the latest wins
            for (int j = 0; j < k; j++) begin
                if (pop[j] && req[j].rd == req[k].rs1) begin
                    rsp[k].rs1_phys = new_tag[j];
                end
                if (pop[j] && req[j].rd == req[k].rs2) begin
                    rsp[k].rs2_phys = new_tag[j];
                end
                // Repeated rd chains through the older slot
                if (pop[j] && req[j].rd == req[k].rd) begin
                    old_tag = new_tag[j];
                end
            end

            // Refused slots drop valid, others pass decode valid through
            rsp[k].valid       = need[k] ? pop[k] : req[k].valid;
            rsp[k].rd_phys     = new_tag[k];
            // Only a real allocation replaces a mapping
            rsp[k].old_rd_phys = pop[k] ? old_tag : '0;
        end
    end

    // ==========================================================
    // Table update
    // ==========================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity mapping, x_i lives in physical i
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else begin
            // Later slots are written last and win on the same rd
            for (int k = 0; k < `RN_WIDTH; k++) begin
                if (pop[k]) begin
                    map_q[req[k].rd] <= new_tag[k];
                end
            end
        end
    end

    // ==========================================================
    // Checks
    // ==========================================================

    // x0 stays hardwired across every update
    a_x0_maps_zero : assert property (
        @(posedge clk) disable iff (!reset)
        map_q[0] == '0
    ) else $error("alias table entry 0 holds %0d", map_q[0]);

    // The free list never loses a tag to an x0 destination
    a_no_pop_for_x0 : assert property (
        @(posedge clk) disable iff (!reset)
        (pop & rd_zero) == '0
    ) else $error("pop raised for x0 destination, pop %b", pop);

endmodule

//--- design/rename_stage.sv
`include "rename_defines.svh"

module rename_stage (
    input  logic                                    clk,
    input  logic                                    reset,
    // Decoded group from decode
    input  rename_pkg::rename_req_t [`RN_WIDTH-1:0] req,
    // Renamed group, same cycle as req
    output rename_pkg::rename_rsp_t [`RN_WIDTH-1:0] rsp,
    // Per-slot allocation levels back to decode
    output logic [`RN_WIDTH-1:0]                    ready,
    // Old mappings released by the ROB
    input  rename_pkg::commit_t [`RN_WIDTH-1:0]     commit
);

    // ==========================================================
    // Internal connections
    // ==========================================================

    // Oldest free tags offered to the alias table
    rename_pkg::phys_tag_t [`RN_WIDTH-1:0] head_tags;
    // Free tags held before this group allocates
    logic [`RN_CNT_W-1:0] free_count;
    // Granted slots, consumed from the head at the edge
    logic [`RN_WIDTH-1:0] pop;

    // ==========================================================
    // Alias table
    // ==========================================================

    // Lookup, bypass and grant are combinational
    register_alias_table u_rat (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .head_tags  (head_tags),
        .free_count (free_count),
        .rsp        (rsp),
        .ready      (ready),
        .pop        (pop)
    );

    // ==========================================================
    // Free list
    // ==========================================================

    // Commit pushes land at the same edge as the pops
    phys_reg_free_list u_free_list (
        .clk       (clk),
        .reset     (reset),
        .pop       (pop),
        .head_tags (head_tags),
        .count     (free_count),
        .push      (commit)
    );

endmodule

//--- dv/rename_tb.sv
`include "rename_defines.svh"

module rename_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // ==========================================================
    // Constants and signals
    // ==========================================================

    localparam int N_FIELDS     = 31;
    localparam int MAX_LINES    = 128;
    localparam int RESET_CYCLES = 8;
    // Longest idle gap inserted before a stim line
    localparam int MAX_GAP      = 3;
    // Field offsets within one stim line
    localparam int COMMIT_OFS   = 12;
    localparam int READY_OFS    = 15;
    localparam int RSP_OFS      = 16;

    logic clk;
    logic reset;
    rename_pkg::rename_req_t [`RN_WIDTH-1:0] req;
    rename_pkg::commit_t [`RN_WIDTH-1:0]     commit;
    rename_pkg::rename_rsp_t [`RN_WIDTH-1:0] rsp;
    logic [`RN_WIDTH-1:0]                    ready;

    // Parsed stim lines
    int stim [MAX_LINES][N_FIELDS];
    int n_lines;
    int cycle_limit;
    int cycles;

    rename_stage dut (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .rsp    (rsp),
        .ready  (ready),
        .commit (commit)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ==========================================================
    // Helpers
    // ==========================================================

    task automatic stop_run(input string why);
        $display("ERROR: %s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("MISMATCH time %0t %s expected %0d actual %0d", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "value check");
        end
    endtask

    // Split one text line into decimal fields
    task automatic split_fields(input string s, output int vals [N_FIELDS], output int n);
        int  acc;
        bit  in_num;
        byte c;

        n      = 0;
        acc    = 0;
        in_num = 1'b0;
        for (int i = 0; i <= s.len(); i++) begin
            c = (i < s.len()) ? s[i] : " ";
            if (c >= "0" && c <= "9") begin
                acc    = acc * 10 + (c - "0");
                in_num = 1'b1;
            end else if (in_num) begin
                if (n < N_FIELDS) begin
                    vals[n] = acc;
                end
                n      = n + 1;
                acc    = 0;
                in_num = 1'b0;
            end
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        int    vals [N_FIELDS];
        string line;

        n_lines = 0;
        fd = $fopen("dv/rename_stim.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open dv/rename_stim.txt");
        end
        while ($fgets(line, fd) > 0) begin
            // Comment lines start with #
            if (line.len() > 0 && line[0] != "#") begin
                split_fields(line, vals, n);
                if (n == N_FIELDS && n_lines < MAX_LINES) begin
                    stim[n_lines] = vals;
                    n_lines = n_lines + 1;
                end else if (n != 0) begin
                    stop_run("stim line has the wrong number of fields");
                end
            end
        end
        $fclose(fd);
        if (n_lines == 0) begin
            stop_run("stim file holds no lines");
        end
    endtask

    // Flags field, bit 0 valid and bit 1 rd_we; a commit tag of 0 means no commit
    task automatic drive_line(input int idx);
        for (int k = 0; k < `RN_WIDTH; k++) begin
            req[k].valid     <= stim[idx][4*k][0];
            req[k].rd_we     <= stim[idx][4*k][1];
            req[k].rs1       <= rename_pkg::arch_tag_t'(stim[idx][4*k+1]);
            req[k].rs2       <= rename_pkg::arch_tag_t'(stim[idx][4*k+2]);
            req[k].rd        <= rename_pkg::arch_tag_t'(stim[idx][4*k+3]);
            commit[k].valid     <= (stim[idx][COMMIT_OFS+k] != 0);
            commit[k].free_phys <= rename_pkg::phys_tag_t'(stim[idx][COMMIT_OFS+k]);
        end
    endtask

    task automatic drive_idle();
        req    <= '0;
        commit <= '0;
    endtask

    // Full check for valid slots, valid only for the rest
    task automatic check_line(input int idx, input bit idle);
        int ofs;

        check_value("ready", stim[idx][READY_OFS], int'(ready));
        for (int k = 0; k < `RN_WIDTH; k++) begin
            ofs = RSP_OFS + 5 * k;
            check_value($sformatf("rsp[%0d].valid", k), idle ? 0 : stim[idx][ofs],
                        int'(rsp[k].valid));
            if (!idle && stim[idx][ofs] != 0) begin
                check_value($sformatf("rsp[%0d].rs1_phys", k), stim[idx][ofs+1],
                            int'(rsp[k].rs1_phys));
                check_value($sformatf("rsp[%0d].rs2_phys", k), stim[idx][ofs+2],
                            int'(rsp[k].rs2_phys));
                check_value($sformatf("rsp[%0d].rd_phys", k), stim[idx][ofs+3],
                            int'(rsp[k].rd_phys));
                check_value($sformatf("rsp[%0d].old_rd_phys", k), stim[idx][ofs+4],
                            int'(rsp[k].old_rd_phys));
            end
        end
    endtask

    // ==========================================================
    // Timeout
    // ==========================================================

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("ERROR: timeout after %0d cycles", cycles);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        int gap;

        void'($urandom(32'h9306));
        cycle_limit = 0;
        reset  = 1'b0;
        req    = '0;
        commit = '0;
        load_stim();
        // Each line plus its gap, with slack, plus reset
        cycle_limit = 2 * n_lines + MAX_GAP * n_lines + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;

        for (int i = 0; i < n_lines; i++) begin
            // Idle cycles leave the count and the table alone
            gap = $urandom % (MAX_GAP + 1);
            repeat (gap) begin
                @(posedge clk);
                drive_idle();
                @(negedge clk);
                check_line(i, 1'b1);
            end
            @(posedge clk);
            drive_line(i);
            @(negedge clk);
            check_line(i, 1'b0);
        end

        @(posedge clk);
        drive_idle();
        $display("Test passed");
        $finish;
    end

endmodule

//--- dv/rename_stim.txt
# Per slot 0..2: flags(bit0 valid, bit1 rd_we) rs1 rs2 rd; then commit tags 0..2 (0 = none)
# Then expected ready (decimal), per slot 0..2: valid rs1_phys rs2_phys rd_phys old_rd_phys
3 1 2 5 3 3 4 6 3 7 8 7 0 0 0 7 1 1 2 32 5 1 3 4 33 6 1 7 8 34 7
3 5 6 10 3 10 7 10 3 10 0 0 0 0 0 7 1 32 33 35 10 1 35 34 36 35 1 36 0 0 0
1 0 10 0 3 10 5 0 3 0 0 3 0 0 0 7 1 0 36 0 0 1 36 32 0 0 1 0 0 37 3
3 0 0 11 3 0 0 12 3 0 0 13 0 0 0 7 1 0 0 38 11 1 0 0 39 12 1 0 0 40 13
3 0 0 14 3 0 0 15 3 0 0 16 0 0 0 7 1 0 0 41 14 1 0 0 42 15 1 0 0 43 16
3 0 0 17 3 0 0 18 3 0 0 19 0 0 0 7 1 0 0 44 17 1 0 0 45 18 1 0 0 46 19
3 0 0 20 3 0 0 21 3 0 0 22 0 0 0 7 1 0 0 47 20 1 0 0 48 21 1 0 0 49 22
3 0 0 23 3 0 0 24 3 0 0 25 0 0 0 7 1 0 0 50 23 1 0 0 51 24 1 0 0 52 25
3 0 0 26 3 0 0 27 3 0 0 28 0 0 0 7 1 0 0 53 26 1 0 0 54 27 1 0 0 55 28
3 0 0 29 3 0 0 30 3 0 0 31 0 0 0 7 1 0 0 56 29 1 0 0 57 30 1 0 0 58 31
3 5 0 5 3 5 0 6 3 6 0 7 0 0 0 7 1 32 0 59 32 1 59 0 60 33 1 60 0 61 34
3 0 0 1 1 1 0 0 0 0 0 0 0 0 0 3 1 0 0 62 1 1 62 0 0 0 0 0 0 0 0
3 0 0 2 3 0 0 3 3 0 0 4 0 0 0 1 1 0 0 63 2 0 0 0 0 0 0 0 0 0 0
3 0 0 8 1 3 2 0 1 4 8 0 11 0 13 0 0 0 0 0 0 1 37 63 0 0 1 4 8 0 0
3 0 0 2 3 2 0 4 3 0 0 8 14 15 16 3 1 0 0 11 63 1 11 0 13 4 0 0 0 0 0
3 4 0 8 1 8 2 0 3 0 0 9 17 0 0 7 1 13 0 14 8 1 14 11 0 0 1 0 0 15 9
3 9 0 9 3 9 9 9 3 0 0 9 0 0 0 3 1 15 0 16 15 1 16 16 17 16 0 0 0 0 0
1 9 8 0 0 0 0 0 0 0 0 0 18 19 20 0 1 17 14 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 10 3 0 0 11 3 0 0 12 21 22 0 7 1 0 0 18 36 1 0 0 19 38 1 0 0 20 39
1 10 11 0 3 0 0 13 0 0 0 0 0 0 0 3 1 18 19 0 0 1 0 0 21 40 0 0 0 0 0
3 13 12 14 3 0 0 15 1 14 15 0 23 24 25 1 1 21 20 22 41 0 0 0 0 0 1 22 42 0 0
3 14 0 15 3 15 15 0 3 15 1 15 0 0 0 7 1 22 0 23 42 1 23 23 0 0 1 23 62 24 23
1 0 1 0 1 2 3 0 1 4 5 0 0 0 0 1 1 0 62 0 0 1 11 37 0 0 1 13 59 0 0
1 6 7 0 1 8 9 0 1 10 11 0 0 0 0 1 1 60 61 0 0 1 14 17 0 0 1 18 19 0 0
1 12 13 0 1 14 15 0 1 16 17 0 0 0 0 1 1 20 21 0 0 1 22 24 0 0 1 43 44 0 0
1 18 19 0 1 20 21 0 1 22 23 0 0 0 0 1 1 45 46 0 0 1 47 48 0 0 1 49 50 0 0
1 24 25 0 1 26 27 0 1 28 29 0 0 0 0 1 1 51 52 0 0 1 53 54 0 0 1 55 56 0 0
1 30 31 0 1 0 0 0 1 0 0 0 0 0 0 1 1 57 58 0 0 1 0 0 0 0 1 0 0 0 0

//--- rename.f
+incdir+design
design/rename_pkg.sv
design/phys_reg_free_list.sv
design/register_alias_table.sv
design/rename_stage.sv
dv/rename_tb.sv

//--- Bender.yml
package:
  name: rename

sources:
  - include_dirs:
      - design
    files:
      - design/rename_pkg.sv
      - design/phys_reg_free_list.sv
      - design/register_alias_table.sv
      - design/rename_stage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/rename_tb.sv
